/* source/sdram_settings.svh */
// ----------------------------------------
// SDRAM maintenance timing settings
// Cycle counts at 200 MHz for the power-up
// sequence, auto-refresh and mode word
// ----------------------------------------
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// Power-up wait, 100 us of NOPs with CKE high
`define SDRAM_INIT_WAIT_CYC 20000

// Precharge period tRP, NOPs after PALL
`define SDRAM_T_RP_CYC 4

// Row cycle tRC, NOPs after REF
`define SDRAM_T_RC_CYC 13

// Mode register set time tMRD
`define SDRAM_T_MRD_CYC 2

// Refresh interval, 8192 rows in 64 ms
`define SDRAM_REF_INTERVAL_CYC 1560

// CL 3, sequential, burst of 1
`define SDRAM_MODE_WORD 13'h030

// Wait and interval counter width
`define SDRAM_CNT_W 15

`endif

/* source/sdram_pkg.sv */
// ----------------------------------------
// SDRAM maintenance types
// Command codes and the two views of the
// 4-bit command word
// ----------------------------------------
package sdram_pkg;

    // Command codes as {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_INHIBIT = 4'b1111, // Chip deselected
        CMD_NOP     = 4'b0111,
        CMD_PALL    = 4'b0010, // Precharge, A10 selects all banks
        CMD_REF     = 4'b0001, // Auto-refresh
        CMD_MRS     = 4'b0000  // Mode register set, word on address bus
    } sdram_cmd_e;

    // Pin view, one field per strobe
    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } sdram_pins_s;

    // Same word seen as a code or as pins
    // Sequencers write code, pin drivers read pins
    typedef union packed {
        sdram_cmd_e  code;
        sdram_pins_s pins;
    } sdram_cmd_u;

endpackage

/* source/sdram_init_seq.sv */
// ----------------------------------------
// SDRAM power-up initialization sequencer
// CKE, 100 us wait, PALL, two REFs, MRS,
// then holds init_done high
// ----------------------------------------
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_init_seq import sdram_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    output sdram_cmd_u  init_cmd,  // Command code to the controller
    output logic [12:0] init_addr, // A10 for PALL, mode word for MRS
    output logic        cke,
    output logic        init_done  // Level, stays high once set
);

    // FSM states
    localparam logic [3:0]
        st_reset    = 4'd0,  // CKE low, inhibit
        st_wait     = 4'd1,  // Power-up NOPs
        st_pall     = 4'd2,
        st_pall_nop = 4'd3,
        st_ref1     = 4'd4,
        st_ref1_nop = 4'd5,
        st_ref2     = 4'd6,
        st_ref2_nop = 4'd7,
        st_mrs      = 4'd8,
        st_mrs_nop  = 4'd9,
        st_done     = 4'd10;

    // Last count value of each NOP stretch
    localparam logic [`SDRAM_CNT_W-1:0] wait_last = `SDRAM_CNT_W'(`SDRAM_INIT_WAIT_CYC - 1);
    localparam logic [`SDRAM_CNT_W-1:0] rp_last   = `SDRAM_CNT_W'(`SDRAM_T_RP_CYC - 1);
    localparam logic [`SDRAM_CNT_W-1:0] rc_last   = `SDRAM_CNT_W'(`SDRAM_T_RC_CYC - 1);
    localparam logic [`SDRAM_CNT_W-1:0] mrd_last  = `SDRAM_CNT_W'(`SDRAM_T_MRD_CYC - 1);

    logic [3:0]              state, next_state;
    logic [`SDRAM_CNT_W-1:0] nop_cnt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    // NOP counter, restarts on every state change
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nop_cnt <= '0;
        end else if (next_state != state) begin
            nop_cnt <= '0;
        end else if (state != st_done) begin
            nop_cnt <= nop_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset:    next_state = st_wait; // First clock out of reset
            st_wait:     if (nop_cnt == wait_last) next_state = st_pall;
            st_pall:     next_state = st_pall_nop;
            st_pall_nop: if (nop_cnt == rp_last) next_state = st_ref1;
            st_ref1:     next_state = st_ref1_nop;
            st_ref1_nop: if (nop_cnt == rc_last) next_state = st_ref2;
            st_ref2:     next_state = st_ref2_nop;
            st_ref2_nop: if (nop_cnt == rc_last) next_state = st_mrs;
            st_mrs:      next_state = st_mrs_nop;
            st_mrs_nop:  if (nop_cnt == mrd_last) next_state = st_done;
            st_done:     next_state = st_done; // Init never repeats
            default:     next_state = st_reset;
        endcase
    end

    // Moore outputs
    always_comb begin
        init_cmd.code = CMD_NOP;
        init_addr     = '0;
        case (state)
            st_reset: init_cmd.code = CMD_INHIBIT;
            st_pall: begin
                init_cmd.code = CMD_PALL;
                init_addr     = 13'h0400; // A10, all banks
            end
            st_ref1, st_ref2: init_cmd.code = CMD_REF;
            st_mrs: begin
                init_cmd.code = CMD_MRS;
                init_addr     = `SDRAM_MODE_WORD;
            end
            default: init_cmd.code = CMD_NOP;
        endcase
    end

    assign cke       = (state != st_reset); // Rises with the first clock
    assign init_done = (state == st_done);

endmodule

/* source/sdram_refresh_seq.sv */
// ----------------------------------------
// SDRAM auto-refresh sequencer
// PALL, tRP of NOPs, REF, tRC of NOPs and
// an end pulse on the last NOP
// ----------------------------------------
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_refresh_seq import sdram_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       ref_enable, // Level from the controller
    output sdram_cmd_u ref_cmd,
    output logic       ref_a10,    // High only with PALL
    output logic       end_ref     // One cycle, last tRC NOP
);

    // FSM states
    localparam logic [2:0]
        idle     = 3'd0,
        pall     = 3'd1,
        pall_nop = 3'd2,
        ref_st   = 3'd3,
        ref_nop  = 3'd4;

    localparam logic [`SDRAM_CNT_W-1:0] rp_last = `SDRAM_CNT_W'(`SDRAM_T_RP_CYC - 1);
    localparam logic [`SDRAM_CNT_W-1:0] rc_last = `SDRAM_CNT_W'(`SDRAM_T_RC_CYC - 1);

    logic [2:0]              state, next_state;
    logic [`SDRAM_CNT_W-1:0] nop_cnt;
    logic                    pall_nop_end;
    logic                    ref_nop_end;

    assign pall_nop_end = (nop_cnt == rp_last);
    assign ref_nop_end  = (nop_cnt == rc_last);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Counter cleared in the command states, counts NOPs
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nop_cnt <= '0;
        end else if (state == pall || state == ref_st || state == idle) begin
            nop_cnt <= '0;
        end else begin
            nop_cnt <= nop_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state    = state;
        ref_cmd.code  = CMD_NOP;
        ref_a10       = 1'b0;
        end_ref       = 1'b0;
        case (state)
            idle: begin
                if (ref_enable) next_state = pall;
            end
            pall: begin
                ref_cmd.code = CMD_PALL;
                ref_a10      = 1'b1; // All banks
                next_state   = pall_nop;
            end
            pall_nop: begin
                // Waits out tRP here, no return to idle
                if (pall_nop_end) next_state = ref_st;
            end
            ref_st: begin
                ref_cmd.code = CMD_REF;
                next_state   = ref_nop;
            end
            ref_nop: begin
                if (ref_nop_end) begin
                    end_ref    = 1'b1; // Controller drops ref_enable on this
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

endmodule

/* source/sdram_maint_ctrl.sv */
// ----------------------------------------
// SDRAM maintenance controller
// Refresh interval timer, deferral against
// host traffic, command select and pins
// ----------------------------------------
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_maint_ctrl import sdram_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        host_active,  // Pending refresh waits while high
    input  logic        init_done,
    input  logic        cke,
    input  logic        end_ref,
    input  logic [12:0] init_addr,
    input  logic        ref_a10,
    input  sdram_cmd_u  init_cmd,
    input  sdram_cmd_u  ref_cmd,
    output logic        ref_enable,
    output logic        maint_busy,   // Controller owns the bus
    output logic        refresh_late, // Sticky, an interval was missed
    output logic        dram_cke,
    output logic [12:0] dram_addr,
    output logic [1:0]  dram_ba,
    output logic        dram_cs_n,
    output logic        dram_ras_n,
    output logic        dram_cas_n,
    output logic        dram_we_n
);

    localparam logic [`SDRAM_CNT_W-1:0] interval_last =
        `SDRAM_CNT_W'(`SDRAM_REF_INTERVAL_CYC - 1);

    logic [`SDRAM_CNT_W-1:0] interval_cnt;
    logic                    expire;   // Interval elapsed this cycle
    logic                    pending;
    logic                    launch;   // Pending refresh handed to the sequencer
    sdram_cmd_u              cmd_sel;
    logic [12:0]             addr_sel;
    sdram_cmd_u              cmd_q;    // Registered pin word

    assign expire = init_done && (interval_cnt == interval_last);
    assign launch = pending && !host_active && !ref_enable;

    // Free running after init, never waits for a refresh to finish
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            interval_cnt <= '0;
        end else if (init_done) begin
            interval_cnt <= expire ? '0 : interval_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending      <= 1'b0;
            ref_enable   <= 1'b0;
            refresh_late <= 1'b0;
            maint_busy   <= 1'b0;
        end else begin
            if (expire) begin
                pending <= 1'b1;  // New request wins over a same-cycle launch
            end else if (launch) begin
                pending <= 1'b0;
            end
            if (launch) begin
                ref_enable <= 1'b1;
            end else if (end_ref) begin
                ref_enable <= 1'b0;
            end
            // Previous request still waiting on host_active
            if (expire && pending && !launch) begin
                refresh_late <= 1'b1;
            end
            maint_busy <= !init_done || ref_enable; // Lines up with the pins
        end
    end

    // Init owns the bus until done, then the refresh sequencer
    assign cmd_sel  = init_done ? ref_cmd : init_cmd;
    assign addr_sel = init_done ? {2'b00, ref_a10, 10'b0} : init_addr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_q.code <= CMD_INHIBIT;
            dram_cke   <= 1'b0;
            dram_addr  <= '0;
        end else begin
            cmd_q      <= cmd_sel;
            dram_cke   <= cke;
            dram_addr  <= addr_sel;
        end
    end

    assign dram_cs_n  = cmd_q.pins.cs_n;
    assign dram_ras_n = cmd_q.pins.ras_n;
    assign dram_cas_n = cmd_q.pins.cas_n;
    assign dram_we_n  = cmd_q.pins.we_n;
    assign dram_ba    = 2'b00; // Bank ignored for PALL with A10 and REF

endmodule

/* source/sdram_maint_top.sv */
// ----------------------------------------
// SDRAM maintenance top level
// Init sequencer, refresh sequencer and
// the pin-owning controller
// ----------------------------------------
`timescale 1ns/1ps

module sdram_maint_top import sdram_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        host_active,
    output logic        dram_cke,
    output logic [12:0] dram_addr,
    output logic [1:0]  dram_ba,
    output logic        dram_cs_n,
    output logic        dram_ras_n,
    output logic        dram_cas_n,
    output logic        dram_we_n,
    output logic        init_done,
    output logic        maint_busy,
    output logic        refresh_late
);

    sdram_cmd_u  init_cmd;
    logic [12:0] init_addr;
    logic        cke;
    sdram_cmd_u  ref_cmd;
    logic        ref_a10;
    logic        ref_enable;
    logic        end_ref;

    sdram_init_seq init_seq0 (
        .clock     (clock),
        .reset     (reset),
        .init_cmd  (init_cmd),
        .init_addr (init_addr),
        .cke       (cke),
        .init_done (init_done)
    );

    sdram_refresh_seq refresh_seq0 (
        .clock      (clock),
        .reset      (reset),
        .ref_enable (ref_enable),
        .ref_cmd    (ref_cmd),
        .ref_a10    (ref_a10),
        .end_ref    (end_ref)
    );

    sdram_maint_ctrl ctrl0 (
        .clock        (clock),
        .reset        (reset),
        .host_active  (host_active),
        .init_done    (init_done),
        .cke          (cke),
        .end_ref      (end_ref),
        .init_addr    (init_addr),
        .ref_a10      (ref_a10),
        .init_cmd     (init_cmd),
        .ref_cmd      (ref_cmd),
        .ref_enable   (ref_enable),
        .maint_busy   (maint_busy),
        .refresh_late (refresh_late),
        .dram_cke     (dram_cke),
        .dram_addr    (dram_addr),
        .dram_ba      (dram_ba),
        .dram_cs_n    (dram_cs_n),
        .dram_ras_n   (dram_ras_n),
        .dram_cas_n   (dram_cas_n),
        .dram_we_n    (dram_we_n)
    );

endmodule

/* tests/sdram_clock_gen.sv */
// ----------------------------------------
// Testbench clock and reset source
// 40 ns clock, reset held for 8 cycles
// ----------------------------------------
`timescale 1ns/1ps

module sdram_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0; // Released just after the 8th edge
    end

endmodule

/* tests/sdram_maint_chk.sv */
// ----------------------------------------
// SDRAM pin protocol checker
// Command legality and REF spacing seen
// at the controller pins
// ----------------------------------------
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_maint_chk import sdram_pkg::*; (
    input logic        clock,
    input logic        reset,
    input logic        dram_cke,
    input logic [12:0] dram_addr,
    input logic        dram_cs_n,
    input logic        dram_ras_n,
    input logic        dram_cas_n,
    input logic        dram_we_n,
    input logic        maint_busy
);

    sdram_cmd_u cmd_w;     // Pin sample decoded as a code
    logic [7:0] since_ref; // Non-REF cycles since the last REF, saturates

    assign cmd_w.pins = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            since_ref <= 8'hff;
        end else if (cmd_w.code == CMD_REF) begin
            since_ref <= 8'h00;
        end else if (since_ref != 8'hff) begin
            since_ref <= since_ref + 8'h01;
        end
    end

    // PALL and REF need the clock enabled
    cke_low_cmd: assert property (@(posedge clock) disable iff (reset)
        (cmd_w.code == CMD_PALL || cmd_w.code == CMD_REF) |-> dram_cke)
        else $error("PALL or REF issued with CKE low");

    ref_spacing: assert property (@(posedge clock) disable iff (reset)
        (cmd_w.code == CMD_REF) |-> (since_ref >= 8'(`SDRAM_T_RC_CYC)))
        else $error("REF issued inside tRC of the previous REF");

    pall_a10: assert property (@(posedge clock) disable iff (reset)
        (cmd_w.code == CMD_PALL) |-> dram_addr[10])
        else $error("PALL without A10");

    // Bus released to the host, only idle commands
    idle_cmd: assert property (@(posedge clock) disable iff (reset)
        !maint_busy |-> (cmd_w.code == CMD_NOP || cmd_w.code == CMD_INHIBIT))
        else $error("Command driven while maint_busy is low");

endmodule

bind sdram_maint_top sdram_maint_chk chk0 (
    .clock      (clock),
    .reset      (reset),
    .dram_cke   (dram_cke),
    .dram_addr  (dram_addr),
    .dram_cs_n  (dram_cs_n),
    .dram_ras_n (dram_ras_n),
    .dram_cas_n (dram_cas_n),
    .dram_we_n  (dram_we_n),
    .maint_busy (maint_busy)
);

/* tests/sdram_tb.sv */
// ----------------------------------------
// SDRAM maintenance testbench
// Init sequence, refresh timing, rate,
// deferral and missed interval
// ----------------------------------------
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_tb import sdram_pkg::*;;

    localparam int wait_cyc = `SDRAM_INIT_WAIT_CYC;
    localparam int rp_cyc   = `SDRAM_T_RP_CYC;
    localparam int rc_cyc   = `SDRAM_T_RC_CYC;
    localparam int mrd_cyc  = `SDRAM_T_MRD_CYC;
    localparam int interval = `SDRAM_REF_INTERVAL_CYC;
    // Pin cycle of MRS, two register stages after reset release
    localparam int mrs_pin     = 2 + wait_cyc + 1 + rp_cyc + 1 + rc_cyc + 1 + rc_cyc;
    localparam int done_cycle  = mrs_pin + mrd_cyc; // init_done high from here
    localparam int busy_off    = rp_cyc + 1 + rc_cyc + 1; // maint_busy low, from PALL
    localparam int expire_lead = 4; // Expiry to PALL at the pins
    localparam int wait_limit  = done_cycle + 4 * interval; // Edge guard of wait_cycle

    logic clock, reset, host_active;
    logic dram_cke, dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n;
    logic [12:0] dram_addr;
    logic [1:0]  dram_ba;
    logic init_done, maint_busy, refresh_late;
    sdram_cmd_u pin_w;

    int    edge_cnt;   // Rising edges since reset release
    int    errors, tests_run, tests_failed, test_start_errors;
    int    seed = 32'h9d9f;
    int    pall_q[$];  // Pin cycles of every refresh PALL
    int    next_expiry; // Cycle of the next interval expiry
    int    ref_off;
    bit    in_ref;
    bit    aborted;    // A wait ran out, later tests skipped
    string test_name = "reset_state";

    sdram_clock_gen clk_gen0 (.clock(clock), .reset(reset));

    sdram_maint_top dut0 (
        .clock(clock), .reset(reset), .host_active(host_active),
        .dram_cke(dram_cke), .dram_addr(dram_addr), .dram_ba(dram_ba),
        .dram_cs_n(dram_cs_n), .dram_ras_n(dram_ras_n),
        .dram_cas_n(dram_cas_n), .dram_we_n(dram_we_n),
        .init_done(init_done), .maint_busy(maint_busy), .refresh_late(refresh_late)
    );

    assign pin_w.pins = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};

    // Expected pin command, init by pin cycle or refresh by offset from PALL
    function automatic sdram_cmd_e expected_cmd(input int step, input bit init_phase);
        int t;
        int ref1_t;
        int ref2_t;
        t      = step - 2;
        ref1_t = wait_cyc + 1 + rp_cyc;
        ref2_t = ref1_t + 1 + rc_cyc;
        if (!init_phase) begin
            if (step == 0) return CMD_PALL;
            if (step == rp_cyc + 1) return CMD_REF;
            return CMD_NOP;
        end
        if (t < 0) return CMD_INHIBIT;
        if (t == wait_cyc) return CMD_PALL;
        if (t == ref1_t || t == ref2_t) return CMD_REF;
        if (t == ref2_t + 1 + rc_cyc) return CMD_MRS;
        return CMD_NOP;
    endfunction

    task automatic value_error(input string what, input int exp, input int act);
        $display("** Error %s: %s at cycle %0d, expected 0x%0h actual 0x%0h",
                 test_name, what, edge_cnt, exp, act);
        errors++;
    endtask

    task automatic finish_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > test_start_errors) begin
            tests_failed++;
            $display("Test %s FAILED with %0d errors", test_name, errors - test_start_errors);
        end else begin
            $display("Test %s ok", test_name);
        end
    endtask

    // Returns 1 ns after the edge that reaches the target
    task automatic wait_cycle(input int target);
        int guard;
        guard = 0;
        while (!aborted && edge_cnt < target && guard < wait_limit) begin
            @(posedge clock);
            #1;
            guard++;
        end
        if (!aborted && edge_cnt < target) timeout_abort("a cycle count");
    endtask

    task automatic wait_palls(input int count, input int limit);
        int guard;
        guard = 0;
        while (!aborted && pall_q.size() < count && guard < limit) begin
            @(posedge clock);
            #1;
            guard++;
        end
        if (!aborted && pall_q.size() < count) timeout_abort("a refresh PALL");
    endtask

    always @(posedge clock) begin
        if (reset) edge_cnt <= 0;
        else edge_cnt <= edge_cnt + 1;
    end

    // Comparing process, samples mid-cycle
    always @(negedge clock) begin
        if (!reset && dram_ba !== 2'b00)
            value_error("dram_ba", 0, int'(dram_ba)); // Bank pins never used
        if (!reset && edge_cnt <= done_cycle + 1) begin
            if (pin_w.code !== expected_cmd(edge_cnt, 1'b1))
                value_error("init command", int'(expected_cmd(edge_cnt, 1'b1)),
                            int'(pin_w.code));
            if (pin_w.code == CMD_MRS && dram_addr !== `SDRAM_MODE_WORD)
                value_error("MRS address", int'(`SDRAM_MODE_WORD), int'(dram_addr));
            if (pin_w.code == CMD_PALL && dram_addr[10] !== 1'b1)
                value_error("init PALL A10", 1, int'(dram_addr[10]));
            if (dram_cke !== (edge_cnt >= 2))
                value_error("dram_cke", int'(edge_cnt >= 2), int'(dram_cke));
            if (init_done !== (edge_cnt >= done_cycle))
                value_error("init_done", int'(edge_cnt >= done_cycle), int'(init_done));
            // Busy while init commands are on the pins
            if (maint_busy !== (edge_cnt >= 1 && edge_cnt <= done_cycle))
                value_error("init maint_busy", int'(edge_cnt >= 1 && edge_cnt <= done_cycle),
                            int'(maint_busy));
        end else if (!reset) begin
            if (pin_w.code == expected_cmd(0, 1'b0)) begin
                pall_q.push_back(edge_cnt);
                ref_off = 0;
                in_ref  = 1'b1;
                if (dram_addr[10] !== 1'b1) value_error("PALL A10", 1, int'(dram_addr[10]));
            end else if (in_ref) begin
                ref_off++;
                if (pin_w.code !== expected_cmd(ref_off, 1'b0))
                    value_error("refresh command", int'(expected_cmd(ref_off, 1'b0)),
                                int'(pin_w.code));
                if (dram_addr[10] !== 1'b0) value_error("refresh A10", 0, int'(dram_addr[10]));
                if (ref_off == busy_off - 1 && maint_busy !== 1'b1)
                    value_error("maint_busy", 1, int'(maint_busy));
                if (ref_off == busy_off) begin
                    if (maint_busy !== 1'b0) value_error("maint_busy", 0, int'(maint_busy));
                    in_ref = 1'b0;
                end
            end else if (pin_w.code !== CMD_NOP) begin
                value_error("idle command", int'(CMD_NOP), int'(pin_w.code));
            end
        end
    end

    // Pins and flags while reset is held
    task automatic reset_values();
        repeat (2) @(posedge clock);
        @(negedge clock);
        if (pin_w.code !== CMD_INHIBIT) value_error("command", int'(CMD_INHIBIT),
                                                    int'(pin_w.code));
        if (dram_cke !== 1'b0) value_error("dram_cke", 0, int'(dram_cke));
        if (init_done !== 1'b0) value_error("init_done", 0, int'(init_done));
        if (maint_busy !== 1'b0) value_error("maint_busy", 0, int'(maint_busy));
        if (refresh_late !== 1'b0) value_error("refresh_late", 0, int'(refresh_late));
        if (dram_ba !== 2'b00) value_error("dram_ba", 0, int'(dram_ba));
    endtask

    // Init commands are compared by the sampling process
    task automatic init_sequence();
        int count;
        count = 0;
        while (reset && count < 20) begin
            @(posedge clock);
            count++;
        end
        if (reset) timeout_abort("reset release");
        else wait_cycle(done_cycle + 2);
    endtask

    task automatic refresh_steps();
        wait_palls(3, 4 * interval);
        if (!aborted) wait_cycle(pall_q[2] + busy_off + 1);
    endtask

    task automatic pall_spacing();
        wait_palls(5, 3 * interval);
        for (int i = 1; i < pall_q.size(); i++) begin
            if (pall_q[i] - pall_q[i-1] != interval)
                value_error("PALL spacing", interval, pall_q[i] - pall_q[i-1]);
        end
    endtask

    // host_active held across one expiry
    task automatic host_deferral();
        int count;
        int fall;
        next_expiry = pall_q[$] - expire_lead + interval;
        wait_cycle(next_expiry - 40 - ($random(seed) & 63));
        host_active = 1'b1;
        count = pall_q.size();
        wait_cycle(next_expiry + 20 + ($random(seed) & 255));
        if (pall_q.size() != count) value_error("PALLs under host_active", count, pall_q.size());
        host_active = 1'b0;
        fall = edge_cnt;
        wait_palls(count + 1, 10);
        if (!aborted) begin
            if (pall_q[count] != fall + 3)
                value_error("deferred PALL cycle", fall + 3, pall_q[count]);
            if (refresh_late !== 1'b0) value_error("refresh_late", 0, int'(refresh_late));
        end
    endtask

    // host_active held over a whole interval
    task automatic missed_interval();
        int count;
        next_expiry = next_expiry + interval;
        wait_cycle(next_expiry - 30);
        host_active = 1'b1;
        count = pall_q.size();
        wait_cycle(next_expiry + interval + 50);
        if (pall_q.size() != count) value_error("PALLs under host_active", count, pall_q.size());
        if (refresh_late !== 1'b1) value_error("refresh_late", 1, int'(refresh_late));
        host_active = 1'b0;
        wait_palls(count + 2, interval + 20);
        if (refresh_late !== 1'b1) value_error("refresh_late sticky", 1, int'(refresh_late));
    endtask

    initial begin
        host_active = 1'b0;
        start_test("reset_state");
        reset_values();
        end_test();

        start_test("initialization");
        init_sequence();
        end_test();

        if (!aborted) begin
            start_test("refresh_sequence");
            refresh_steps();
            end_test();
        end
        if (!aborted) begin
            start_test("refresh_rate");
            pall_spacing();
            end_test();
        end
        if (!aborted) begin
            start_test("deferral");
            host_deferral();
            end_test();
        end
        if (!aborted) begin
            start_test("missed_interval");
            missed_interval();
            end_test();
        end

        finish_run();
    end

endmodule

/* src.f */
+incdir+source
source/sdram_pkg.sv
source/sdram_init_seq.sv
source/sdram_refresh_seq.sv
source/sdram_maint_ctrl.sv
source/sdram_maint_top.sv
tests/sdram_clock_gen.sv
tests/sdram_maint_chk.sv
tests/sdram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SDRAM maintenance testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module sdram_tb -f src.f -o sdram_sim \
    && ./obj_dir/sdram_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
